/* sim.f */
verilog/sar_cfg_pkg.sv
verilog/sar_types_pkg.sv
verilog/sar_intf.sv
verilog/seg_ingress.sv
verilog/frame_buffer_mem.sv
verilog/reassembly_tracker.sv
verilog/frame_egress.sv
verilog/sar_reassembly_top.sv
tb/sar_assertions.sv
tb/tb_sar_reassembly.sv

/* tb/tb_sar_reassembly.sv */
// Testbench for the segment reassembly top level
// Directed tests, reference model of buffer contents, monitors and watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_sar_reassembly;

    localparam int          CLK_PERIOD      = 40;
    localparam int          RESET_CYCLES    = 10;
    localparam int          NUM_TESTS       = 5;
    localparam int          CYCLES_PER_TEST = 2000;
    localparam int          WAIT_LIMIT      = 300;
    localparam int unsigned SEED            = 32'hb000_34ce;
    localparam int          MEM_WORDS       = sar_cfg_pkg::NUM_BUFS * sar_cfg_pkg::WORDS_PER_BUF;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 ms_tick;
    logic                                 in_valid;
    logic [31:0]                          in_word;
    logic                                 in_credit;
    logic                                 frame_credit;
    logic                                 frame_valid;
    logic [sar_cfg_pkg::BUF_ID_WID-1:0]   frame_buf_id;
    logic [sar_cfg_pkg::LEN_WID-1:0]      frame_len;
    logic                                 frame_drop;
    logic [sar_cfg_pkg::BUF_ID_WID-1:0]   drop_buf_id;
    logic [sar_cfg_pkg::MEM_ADDR_WID-1:0] rd_addr;
    logic [31:0]                          rd_data;

    // Reference model and bookkeeping
    logic [31:0] ref_mem [MEM_WORDS];
    int          exp_len [sar_cfg_pkg::NUM_BUFS];
    int          credit_cnt;

    sar_types_pkg::frame_desc_t frames_q [$];
    int                         drops_q  [$];

    sar_reassembly_top UUT (
        .clk,
        .rst_n,
        .ms_tick,
        .in_valid,
        .in_word,
        .in_credit,
        .frame_credit,
        .frame_valid,
        .frame_buf_id,
        .frame_len,
        .frame_drop,
        .drop_buf_id,
        .rd_addr,
        .rd_data
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // Monitors, sampled mid-cycle
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_credit) begin
                credit_cnt++;
            end
            if (frame_valid) begin
                frames_q.push_back({frame_buf_id, frame_len});
            end
            if (frame_drop) begin
                drops_q.push_back(int'(drop_buf_id));
            end
        end
    end

    always @(negedge clk) begin
        if (UUT.u_sar_assertions.fail_cnt != 0) begin
            fail_run("A bound protocol assertion failed, see the error above");
        end
    end

    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        fail_run("Watchdog expired, the tests did not finish in time");
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("FAIL %0t: %s is 0x%08h, expected 0x%08h",
                                $time, what, got, exp));
    endtask

    function automatic logic [31:0] make_header(input int b, input int off,
                                                input int len, input bit last);
        sar_types_pkg::seg_hdr_t hdr;
        hdr.buf_id   = b[sar_cfg_pkg::BUF_ID_WID-1:0];
        hdr.offset   = off[sar_cfg_pkg::OFFSET_WID-1:0];
        hdr.len      = len[sar_cfg_pkg::LEN_WID-1:0];
        hdr.last     = last;
        hdr.reserved = '0;
        return hdr;
    endfunction

    // Waits for a credit, then spends it on one word
    task automatic send_word(input logic [31:0] w);
        while (credit_cnt == 0) begin
            @(posedge clk);
            #2;
        end
        in_valid = 1'b1;
        in_word  = w;
        credit_cnt--;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic send_segment(input int b, input int off, input int len, input bit last);
        int          n;
        logic [31:0] w;
        n = (len + sar_cfg_pkg::DATA_BYTES - 1) / sar_cfg_pkg::DATA_BYTES;
        send_word(make_header(b, off, len, last));
        for (int i = 0; i < n; i++) begin
            w = $urandom;
            ref_mem[b * sar_cfg_pkg::WORDS_PER_BUF + off / sar_cfg_pkg::DATA_BYTES + i] = w;
            send_word(w);
        end
        if (last) begin
            exp_len[b] = off + len;
        end
    endtask

    task automatic grant_credit();
        frame_credit = 1'b1;
        @(posedge clk);
        #2;
        frame_credit = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic tick_ms();
        ms_tick = 1'b1;
        @(posedge clk);
        #2;
        ms_tick = 1'b0;
        repeat (2) @(posedge clk);
        #2;
    endtask

    task automatic wait_frame(output sar_types_pkg::frame_desc_t d);
        int n;
        n = 0;
        while (frames_q.size() == 0) begin
            if (n == WAIT_LIMIT) begin
                fail_run("Timed out waiting for a frame on the output");
            end else begin
                @(posedge clk);
                #2;
                n++;
            end
        end
        d = frames_q.pop_front();
    endtask

    // Checks the descriptor, then reads the frame back word by word
    task automatic expect_frame(input int b);
        sar_types_pkg::frame_desc_t d;
        int                         words;
        wait_frame(d);
        check_value("frame buf_id", d.buf_id, b);
        check_value("frame len", d.len, exp_len[b]);
        words = (exp_len[b] + sar_cfg_pkg::DATA_BYTES - 1) / sar_cfg_pkg::DATA_BYTES;
        for (int i = 0; i < words; i++) begin
            rd_addr = b * sar_cfg_pkg::WORDS_PER_BUF + i;
            @(posedge clk);
            #2;
            check_value($sformatf("buffer %0d word %0d", b, i), rd_data,
                        ref_mem[b * sar_cfg_pkg::WORDS_PER_BUF + i]);
        end
    endtask

    task automatic expect_no_frame(input int cycles);
        repeat (cycles) @(posedge clk);
        #2;
        check_value("frames pending", frames_q.size(), 0);
    endtask

    task automatic settle_credits();
        int n;
        n = 0;
        while (credit_cnt != sar_cfg_pkg::IN_CREDITS && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        check_value("input credit count", credit_cnt, sar_cfg_pkg::IN_CREDITS);
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic test_single_segment();
        grant_credit();
        send_segment(0, 0, 12, 1'b1);
        expect_frame(0);
        settle_credits();
    endtask

    // Last segment arrives first
    task automatic test_out_of_order();
        grant_credit();
        send_segment(1, 32, 10, 1'b1);
        send_segment(1, 0, 16, 1'b0);
        send_segment(1, 16, 16, 1'b0);
        expect_frame(1);
        expect_no_frame(20);
        settle_credits();
    endtask

    task automatic test_interleaved();
        grant_credit();
        grant_credit();
        send_segment(2, 0, 8, 1'b0);
        send_segment(3, 0, 12, 1'b0);
        send_segment(2, 8, 8, 1'b1);
        send_segment(3, 12, 8, 1'b1);
        expect_frame(2);
        expect_frame(3);
        settle_credits();
    endtask

    // Completed frames wait for consumer credits
    task automatic test_credit_gating();
        send_segment(0, 0, 8, 1'b1);
        send_segment(1, 0, 4, 1'b1);
        expect_no_frame(50);
        grant_credit();
        expect_frame(0);
        expect_no_frame(20);
        grant_credit();
        expect_frame(1);
        settle_credits();
    endtask

    task automatic test_timeout_drop();
        int n;
        send_segment(3, 0, 8, 1'b0);
        settle_credits();
        repeat (4) @(posedge clk);
        #2;
        // No drop before the final tick
        repeat (sar_cfg_pkg::TIMEOUT_MS - 1) tick_ms();
        check_value("drops before the last tick", drops_q.size(), 0);
        tick_ms();
        n = 0;
        while (drops_q.size() == 0) begin
            if (n == WAIT_LIMIT) begin
                fail_run("Timed out waiting for frame_drop on buffer 3");
            end else begin
                @(posedge clk);
                #2;
                n++;
            end
        end
        check_value("drop buf_id", drops_q.pop_front(), 3);
        check_value("frames after drop", frames_q.size(), 0);
        // Buffer must be usable again
        grant_credit();
        send_segment(3, 0, 8, 1'b1);
        expect_frame(3);
        settle_credits();
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        rst_n          = 1'b0;
        ms_tick        = 1'b0;
        in_valid       = 1'b0;
        in_word        = '0;
        frame_credit   = 1'b0;
        rd_addr        = '0;
        credit_cnt     = sar_cfg_pkg::IN_CREDITS;
        for (int i = 0; i < sar_cfg_pkg::NUM_BUFS; i++) begin
            exp_len[i] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #2;

        test_single_segment();
        test_out_of_order();
        test_interleaved();
        test_credit_gating();
        test_timeout_drop();

        if (UUT.u_sar_assertions.fail_cnt == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail_run("A bound protocol assertion failed during the run");
        end
    end

endmodule : tb_sar_reassembly

`default_nettype wire

/* tb/sar_assertions.sv */
// Protocol checks bound to the reassembly top level
// Input credits, frame pulse width and segment handshake stability
`timescale 1ns/10ps
`default_nettype none

module sar_assertions (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic in_credit,
    input logic frame_valid,
    input logic seg_valid,
    input logic seg_ready
);
    int          avail_credits;
    int unsigned fail_cnt = 0;

    // Credits the sender holds, as seen on the bus
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            avail_credits <= sar_cfg_pkg::IN_CREDITS;
        end else begin
            avail_credits <= avail_credits - int'(in_valid) + int'(in_credit);
        end
    end

    credit_held: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> avail_credits > 0)
    else begin
        $error("in_valid asserted while the sender holds no credit");
        fail_cnt++;
    end

    // One cycle per frame descriptor
    frame_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |=> !frame_valid)
    else begin
        $error("frame_valid high for two cycles in a row");
        fail_cnt++;
    end

    seg_hold: assert property (@(posedge clk) disable iff (!rst_n)
        seg_valid && !seg_ready |=> seg_valid)
    else begin
        $error("segment descriptor valid dropped before it was accepted");
        fail_cnt++;
    end

endmodule : sar_assertions

bind sar_reassembly_top sar_assertions u_sar_assertions (
    .clk,
    .rst_n,
    .in_valid,
    .in_credit,
    .frame_valid,
    .seg_valid   ( seg_if.valid ),
    .seg_ready   ( seg_if.ready )
);

`default_nettype wire

/* verilog/sar_reassembly_top.sv */
// Top level of the segment reassembly design
// Ingress, frame memory, tracker and egress with their internal links
`timescale 1ns/10ps
`default_nettype none

module sar_reassembly_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 ms_tick,

    // Segment word input
    input  logic                                 in_valid,
    input  logic [31:0]                          in_word,
    output logic                                 in_credit,

    // Frame descriptor output
    input  logic                                 frame_credit,
    output logic                                 frame_valid,
    output logic [sar_cfg_pkg::BUF_ID_WID-1:0]   frame_buf_id,
    output logic [sar_cfg_pkg::LEN_WID-1:0]      frame_len,
    output logic                                 frame_drop,
    output logic [sar_cfg_pkg::BUF_ID_WID-1:0]   drop_buf_id,

    // Consumer read port
    input  logic [sar_cfg_pkg::MEM_ADDR_WID-1:0] rd_addr,
    output logic [31:0]                          rd_data
);
    logic                                 mem_we;
    logic [sar_cfg_pkg::MEM_ADDR_WID-1:0] mem_waddr;
    logic [31:0]                          mem_wdata;

    seg_desc_if   seg_if ();
    frame_desc_if frame_if ();

    // ------------------------------------------------------------
    // Input side and storage
    // ------------------------------------------------------------
    seg_ingress i_seg_ingress (
        .clk,
        .rst_n,
        .in_valid,
        .in_word,
        .in_credit,
        .mem_we,
        .mem_waddr,
        .mem_wdata,
        .seg       ( seg_if )
    );

    frame_buffer_mem i_frame_buffer_mem (
        .clk,
        .we    ( mem_we ),
        .waddr ( mem_waddr ),
        .wdata ( mem_wdata ),
        .raddr ( rd_addr ),
        .rdata ( rd_data )
    );

    // ------------------------------------------------------------
    // Tracking and output side
    // ------------------------------------------------------------
    reassembly_tracker i_reassembly_tracker (
        .clk,
        .rst_n,
        .ms_tick,
        .seg         ( seg_if ),
        .frame       ( frame_if ),
        .frame_drop,
        .drop_buf_id
    );

    frame_egress i_frame_egress (
        .clk,
        .rst_n,
        .frame        ( frame_if ),
        .frame_credit,
        .frame_valid,
        .frame_buf_id,
        .frame_len
    );

endmodule : sar_reassembly_top

`default_nettype wire

/* verilog/frame_egress.sv */
// Frame output stage
// Descriptor queue and consumer credit counter
`timescale 1ns/10ps
`default_nettype none

module frame_egress (
    input  logic                               clk,
    input  logic                               rst_n,
    frame_desc_if.dst                          frame,
    input  logic                               frame_credit,
    output logic                               frame_valid,
    output logic [sar_cfg_pkg::BUF_ID_WID-1:0] frame_buf_id,
    output logic [sar_cfg_pkg::LEN_WID-1:0]    frame_len
);
    typedef logic [$clog2(sar_cfg_pkg::OUT_QUEUE_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(sar_cfg_pkg::OUT_QUEUE_DEPTH):0]   cnt_t;

    sar_types_pkg::frame_desc_t queue [sar_cfg_pkg::OUT_QUEUE_DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t q_cnt;
    cnt_t credits;
    logic push;
    logic send;
    logic sent_q;

    assign frame.ready = q_cnt != cnt_t'(sar_cfg_pkg::OUT_QUEUE_DEPTH);
    assign push        = frame.valid && frame.ready;

    // One frame per credit, never two cycles back to back
    assign send         = (q_cnt != '0) && (credits != '0) && !sent_q;
    assign frame_valid  = send;
    assign frame_buf_id = queue[rd_ptr].buf_id;
    assign frame_len    = queue[rd_ptr].len;

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= frame.desc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_cnt   <= '0;
            credits <= '0;
            sent_q  <= 1'b0;
        end else begin
            sent_q <= send;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !send) begin
                q_cnt <= q_cnt + 1'b1;
            end else if (send && !push) begin
                q_cnt <= q_cnt - 1'b1;
            end
            // Credit in and frame out together cancel
            if (frame_credit && !send) begin
                credits <= credits + 1'b1;
            end else if (send && !frame_credit) begin
                credits <= credits - 1'b1;
            end
        end
    end

endmodule : frame_egress

`default_nettype wire

/* verilog/reassembly_tracker.sv */
// Per-buffer reassembly state
// Byte counting, end detection, timeout drop and frame completion
`timescale 1ns/10ps
`default_nettype none

module reassembly_tracker (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               ms_tick,
    seg_desc_if.dst                            seg,
    frame_desc_if.src                          frame,
    output logic                               frame_drop,
    output logic [sar_cfg_pkg::BUF_ID_WID-1:0] drop_buf_id
);
    typedef logic [sar_cfg_pkg::LEN_WID-1:0]    len_t;
    typedef logic [sar_cfg_pkg::BUF_ID_WID-1:0] buf_t;
    typedef logic [sar_cfg_pkg::TIMER_WID-1:0]  timer_t;

    len_t   rx_cnt [sar_cfg_pkg::NUM_BUFS];
    len_t   total  [sar_cfg_pkg::NUM_BUFS];
    timer_t timer  [sar_cfg_pkg::NUM_BUFS];
    logic [sar_cfg_pkg::NUM_BUFS-1:0] known;
    logic [sar_cfg_pkg::NUM_BUFS-1:0] busy;
    logic [sar_cfg_pkg::NUM_BUFS-1:0] pend;

    logic expire_any;
    buf_t expire_id;
    len_t new_cnt;
    len_t new_total;
    logic new_known;
    logic seg_done;

    // ------------------------------------------------------------
    // Combinational decisions
    // ------------------------------------------------------------
    // Buffer whose frame is on offer to egress
    always_comb begin
        pend = '0;
        if (frame.valid) begin
            pend[frame.desc.buf_id] = 1'b1;
        end
    end

    // Lowest expired buffer wins
    always_comb begin
        expire_any = 1'b0;
        expire_id  = '0;
        for (int i = sar_cfg_pkg::NUM_BUFS - 1; i >= 0; i--) begin
            if (busy[i] && !pend[i] && timer[i] == timer_t'(sar_cfg_pkg::TIMEOUT_MS)) begin
                expire_any = 1'b1;
                expire_id  = buf_t'(i);
            end
        end
    end

    always_comb begin
        new_cnt   = rx_cnt[seg.buf_id] + seg.len;
        new_known = known[seg.buf_id] | seg.last;
        new_total = seg.last ? len_t'(seg.offset) + seg.len : total[seg.buf_id];
        seg_done  = new_known && (new_cnt == new_total);
    end

    // No new segment while a frame waits or a drop is due
    assign seg.ready = !frame.valid && !expire_any;

    // ------------------------------------------------------------
    // Buffer state
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < sar_cfg_pkg::NUM_BUFS; i++) begin
                rx_cnt[i] <= '0;
                total[i]  <= '0;
                timer[i]  <= '0;
            end
            known       <= '0;
            busy        <= '0;
            frame.valid <= 1'b0;
            frame_drop  <= 1'b0;
            drop_buf_id <= '0;
        end else begin
            frame_drop <= 1'b0;

            // Age every open buffer, saturating at the limit
            if (ms_tick) begin
                for (int i = 0; i < sar_cfg_pkg::NUM_BUFS; i++) begin
                    if (busy[i] && !pend[i] &&
                        timer[i] != timer_t'(sar_cfg_pkg::TIMEOUT_MS)) begin
                        timer[i] <= timer[i] + 1'b1;
                    end
                end
            end

            if (seg.valid && seg.ready) begin
                rx_cnt[seg.buf_id] <= new_cnt;
                total[seg.buf_id]  <= new_total;
                known[seg.buf_id]  <= new_known;
                busy[seg.buf_id]   <= 1'b1;
                timer[seg.buf_id]  <= '0;
                if (seg_done) begin
                    frame.valid <= 1'b1;
                end
            end

            // Free the buffer once egress takes the descriptor
            if (frame.valid && frame.ready) begin
                frame.valid                <= 1'b0;
                rx_cnt[frame.desc.buf_id]  <= '0;
                known[frame.desc.buf_id]   <= 1'b0;
                busy[frame.desc.buf_id]    <= 1'b0;
                timer[frame.desc.buf_id]   <= '0;
            end

            if (expire_any) begin
                rx_cnt[expire_id] <= '0;
                known[expire_id]  <= 1'b0;
                busy[expire_id]   <= 1'b0;
                timer[expire_id]  <= '0;
                frame_drop        <= 1'b1;
                drop_buf_id       <= expire_id;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (seg.valid && seg.ready && seg_done) begin
            frame.desc.buf_id <= seg.buf_id;
            frame.desc.len    <= new_total;
        end
    end

endmodule : reassembly_tracker

`default_nettype wire

/* verilog/frame_buffer_mem.sv */
// Shared frame memory
// One write port from ingress, one registered read port for the consumer
`timescale 1ns/10ps
`default_nettype none

module frame_buffer_mem (
    input  logic                                 clk,
    input  logic                                 we,
    input  logic [sar_cfg_pkg::MEM_ADDR_WID-1:0] waddr,
    input  logic [31:0]                          wdata,
    input  logic [sar_cfg_pkg::MEM_ADDR_WID-1:0] raddr,
    output logic [31:0]                          rdata
);
    logic [31:0] mem [sar_cfg_pkg::NUM_BUFS * sar_cfg_pkg::WORDS_PER_BUF];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule : frame_buffer_mem

`default_nettype wire

/* verilog/seg_ingress.sv */
// Segment input stage
// Word FIFO, header/data decode, frame memory writes and credit return
`timescale 1ns/10ps
`default_nettype none

module seg_ingress (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  logic [31:0]                          in_word,
    output logic                                 in_credit,
    output logic                                 mem_we,
    output logic [sar_cfg_pkg::MEM_ADDR_WID-1:0] mem_waddr,
    output logic [31:0]                          mem_wdata,
    seg_desc_if.src                              seg
);
    typedef logic [$clog2(sar_cfg_pkg::IN_CREDITS)-1:0]   ptr_t;
    typedef logic [$clog2(sar_cfg_pkg::IN_CREDITS+1)-1:0] cnt_t;
    typedef logic [sar_cfg_pkg::MEM_ADDR_WID-1:0]         addr_t;
    typedef logic [sar_cfg_pkg::LEN_WID-1:0]              len_t;

    logic [31:0] fifo_mem [sar_cfg_pkg::IN_CREDITS];
    ptr_t        wr_ptr;
    ptr_t        rd_ptr;
    cnt_t        fifo_cnt;
    logic        pop;

    sar_types_pkg::seg_word_u pop_word;
    sar_types_pkg::seg_hdr_t  hdr_q;

    logic  seg_open;
    logic  desc_pend;
    len_t  words_left;
    addr_t word_idx;

    // ------------------------------------------------------------
    // Input FIFO
    // ------------------------------------------------------------
    // Sender only pushes while holding a credit, so no overflow
    always_ff @(posedge clk) begin
        if (in_valid) begin
            fifo_mem[wr_ptr] <= in_word;
        end
    end

    // Hold off while a descriptor is pending or waiting
    assign pop       = (fifo_cnt != '0) && !desc_pend && !seg.valid;
    assign in_credit = pop;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (in_valid && !pop) begin
                fifo_cnt <= fifo_cnt + 1'b1;
            end else if (pop && !in_valid) begin
                fifo_cnt <= fifo_cnt - 1'b1;
            end
        end
    end

    assign pop_word.data = fifo_mem[rd_ptr];

    // ------------------------------------------------------------
    // Segment decode
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seg_open   <= 1'b0;
            desc_pend  <= 1'b0;
            seg.valid  <= 1'b0;
            mem_we     <= 1'b0;
            words_left <= '0;
            word_idx   <= '0;
        end else begin
            mem_we    <= 1'b0;
            desc_pend <= 1'b0;
            if (desc_pend) begin
                seg.valid <= 1'b1;
            end
            if (seg.valid && seg.ready) begin
                seg.valid <= 1'b0;
            end
            if (pop && !seg_open) begin
                // Header word
                if (pop_word.hdr.len == '0) begin
                    seg.valid <= 1'b1;
                end else begin
                    seg_open   <= 1'b1;
                    words_left <= len_t'((pop_word.hdr.len + sar_cfg_pkg::DATA_BYTES - 1) /
                                         sar_cfg_pkg::DATA_BYTES);
                    word_idx   <= '0;
                end
            end else if (pop) begin
                // Data word, written on the next edge
                mem_we     <= 1'b1;
                word_idx   <= word_idx + 1'b1;
                words_left <= words_left - 1'b1;
                if (words_left == len_t'(1)) begin
                    seg_open  <= 1'b0;
                    desc_pend <= 1'b1;
                end
            end
        end
    end

    // Header fields and write data
    always_ff @(posedge clk) begin
        if (pop && !seg_open) begin
            hdr_q <= pop_word.hdr;
        end
        if (pop && seg_open) begin
            mem_waddr <= addr_t'(hdr_q.buf_id) * addr_t'(sar_cfg_pkg::WORDS_PER_BUF) +
                         addr_t'(hdr_q.offset / sar_cfg_pkg::DATA_BYTES) + word_idx;
            mem_wdata <= pop_word.data;
        end
    end

    assign seg.buf_id = hdr_q.buf_id;
    assign seg.offset = hdr_q.offset;
    assign seg.len    = hdr_q.len;
    assign seg.last   = hdr_q.last;

endmodule : seg_ingress

`default_nettype wire

/* verilog/sar_intf.sv */
// Internal valid/ready interfaces
// Segment descriptor and frame descriptor links
`timescale 1ns/10ps
`default_nettype none

// ------------------------------------------------------------
// Segment descriptor, ingress to tracker
// ------------------------------------------------------------
interface seg_desc_if;
    logic                               valid;
    logic                               ready;
    logic [sar_cfg_pkg::BUF_ID_WID-1:0] buf_id;
    logic [sar_cfg_pkg::OFFSET_WID-1:0] offset;
    logic [sar_cfg_pkg::LEN_WID-1:0]    len;
    logic                               last;

    modport src (
        output valid, buf_id, offset, len, last,
        input  ready
    );

    modport dst (
        input  valid, buf_id, offset, len, last,
        output ready
    );
endinterface : seg_desc_if

// ------------------------------------------------------------
// Frame descriptor, tracker to egress
// ------------------------------------------------------------
interface frame_desc_if;
    logic                       valid;
    logic                       ready;
    sar_types_pkg::frame_desc_t desc;

    modport src (
        output valid, desc,
        input  ready
    );

    modport dst (
        input  valid, desc,
        output ready
    );
endinterface : frame_desc_if

`default_nettype wire

/* verilog/sar_types_pkg.sv */
// Data types shared across the reassembly design
// Segment header, header/data word union and frame descriptor
`default_nettype none

package sar_types_pkg;

    // First word of every segment
    typedef struct packed {
        logic [sar_cfg_pkg::BUF_ID_WID-1:0] buf_id;
        logic [sar_cfg_pkg::OFFSET_WID-1:0] offset;
        logic [sar_cfg_pkg::LEN_WID-1:0]    len;
        logic                               last;
        logic [11:0]                        reserved;
    } seg_hdr_t;

    // A bus word is either a header or payload
    typedef union packed {
        seg_hdr_t    hdr;
        logic [31:0] data;
    } seg_word_u;

    // Completed frame handed to the consumer
    typedef struct packed {
        logic [sar_cfg_pkg::BUF_ID_WID-1:0] buf_id;
        logic [sar_cfg_pkg::LEN_WID-1:0]    len;
    } frame_desc_t;

endpackage : sar_types_pkg

`default_nettype wire

/* verilog/sar_cfg_pkg.sv */
// Configuration constants for the segment reassembly design
// Buffer geometry, field widths, credits and timeout
`default_nettype none

package sar_cfg_pkg;

    // Frame buffers
    localparam int NUM_BUFS        = 4;
    localparam int BUF_ID_WID      = $clog2(NUM_BUFS);
    localparam int MAX_FRAME_BYTES = 256;
    localparam int OFFSET_WID      = $clog2(MAX_FRAME_BYTES);
    localparam int LEN_WID         = $clog2(MAX_FRAME_BYTES + 1);

    // Memory organisation
    localparam int DATA_BYTES      = 4;
    localparam int WORDS_PER_BUF   = MAX_FRAME_BYTES / DATA_BYTES;
    localparam int MEM_ADDR_WID    = $clog2(NUM_BUFS * WORDS_PER_BUF);

    // Flow control at the two external boundaries
    localparam int IN_CREDITS      = 4;
    localparam int OUT_QUEUE_DEPTH = NUM_BUFS;

    // Buffer timeout in millisecond ticks
    localparam int TIMEOUT_MS      = 8;
    localparam int TIMER_WID       = 4;

endpackage : sar_cfg_pkg

`default_nettype wire
